/* Makefile */
# Verilator simulation of the PS/2 keypad receiver
# Any variable below can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= ps2_keypad_tb
FILELIST  ?= ps2_keypad.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= ** FAIL **

.PHONY: sim clean

# Build, run, then search the log for the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/ps2_keypad_defines.svh */
`ifndef PS2_KEYPAD_DEFINES_SVH
`define PS2_KEYPAD_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Line filter
//////////////////////////////////////////////////////////////////////

// System clock cycles per filter sample tick
`define PS2_SAMPLE_DIV 4
// Equal samples in a row before a filtered line may change
`define PS2_FILTER_LEN 8

//////////////////////////////////////////////////////////////////////
// Frame receiver and decoder
//////////////////////////////////////////////////////////////////////

// Sample ticks without a clock fall before a partial frame is dropped
`define PS2_BIT_TIMEOUT 1024

`define PS2_CODE_BREAK 8'hF0
`define PS2_CODE_EXT 8'hE0
`define KEY_UNKNOWN 5'd31

`endif

/* logic/ps2_frame_receiver.sv */
`include "ps2_keypad_defines.svh"

module ps2_frame_receiver
    import ps2_keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       ps2_clk_f,
    input  logic       ps2_data_f,
    output scan_code_t code,
    output logic       code_valid,
    output logic       frame_error
);

    localparam int FRAME_BITS = 11;
    localparam int DIV_W = $clog2(`PS2_SAMPLE_DIV);
    localparam int IDLE_W = $clog2(`PS2_BIT_TIMEOUT);

    rx_state_t state;

    logic ps2_clk_q;
    logic clk_fall;
    logic [3:0] bit_cnt;
    logic [FRAME_BITS-1:0] frame_q;

    logic [DIV_W-1:0] div_cnt;
    logic tick;
    logic [IDLE_W-1:0] idle_cnt;
    logic timeout;

    logic start_ok;
    logic parity_ok;
    logic stop_ok;
    logic frame_ok;

    //////////////////////////////////////////////////////////////////////
    // Clock fall detection
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ps2_clk_q <= 1'b1;
        end else begin
            ps2_clk_q <= ps2_clk_f;
        end
    end

    assign clk_fall = ps2_clk_q & ~ps2_clk_f;

    //////////////////////////////////////////////////////////////////////
    // Frame state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= RX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (clk_fall) begin
                        state <= RX_SHIFT;
                        bit_cnt <= 4'd1;
                    end
                end
                RX_SHIFT: begin
                    if (clk_fall) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                            state <= RX_CHECK;
                        end
                    end else if (timeout) begin
                        state <= RX_IDLE;
                    end
                end
                RX_CHECK: begin
                    state <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Bits arrive LSB first, so the start bit ends up in bit 0
    always_ff @(posedge clk) begin
        if (clk_fall && state != RX_CHECK) begin
            frame_q <= {ps2_data_f, frame_q[FRAME_BITS-1:1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bit timeout
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick = (div_cnt == DIV_W'(`PS2_SAMPLE_DIV - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idle_cnt <= '0;
        end else if (state != RX_SHIFT || clk_fall) begin
            idle_cnt <= '0;
        end else if (tick) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign timeout = tick && (idle_cnt == IDLE_W'(`PS2_BIT_TIMEOUT - 1));

    //////////////////////////////////////////////////////////////////////
    // Frame checks and outputs
    //////////////////////////////////////////////////////////////////////

    assign start_ok = ~frame_q[0];
    // Odd parity covers the eight data bits and the parity bit
    assign parity_ok = ^frame_q[9:1];
    assign stop_ok = frame_q[10];
    assign frame_ok = start_ok & parity_ok & stop_ok;

    assign code = frame_q[8:1];
    assign code_valid = (state == RX_CHECK) && frame_ok;
    assign frame_error = (state == RX_CHECK) && !frame_ok;

    assert property (@(posedge clk) disable iff (!rstn) !(code_valid && frame_error))
    else $error("ps2_frame_receiver: code_valid and frame_error both high");

endmodule

/* logic/ps2_key_decoder.sv */
`include "ps2_keypad_defines.svh"

module ps2_key_decoder
    import ps2_keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  scan_code_t code,
    input  logic       code_valid,
    output key_index_t key_index,
    output logic       key_valid,
    output logic       key_release
);

    dec_state_t state;
    dec_state_t state_nxt;
    logic emit_key;

    // Scan code set 2 make codes of the keys this pad knows about
    function automatic key_index_t lookup_key(input scan_code_t sc);
        key_index_t idx;
        case (sc)
            8'h45: idx = 5'd0;
            8'h16: idx = 5'd1;
            8'h1E: idx = 5'd2;
            8'h26: idx = 5'd3;
            8'h25: idx = 5'd4;
            8'h2E: idx = 5'd5;
            8'h36: idx = 5'd6;
            8'h3D: idx = 5'd7;
            8'h3E: idx = 5'd8;
            8'h46: idx = 5'd9;
            8'h1C: idx = 5'd10;
            8'h32: idx = 5'd11;
            8'h21: idx = 5'd12;
            8'h23: idx = 5'd13;
            8'h24: idx = 5'd14;
            8'h2B: idx = 5'd15;
            8'h5A: idx = 5'd16;
            8'h66: idx = 5'd17;
            8'h0D: idx = 5'd18;
            default: idx = `KEY_UNKNOWN;
        endcase
        return idx;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Prefix tracking
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        emit_key = 1'b0;
        if (code_valid) begin
            if (code == `PS2_CODE_EXT) begin
                state_nxt = DEC_EXT;
            end else if (code == `PS2_CODE_BREAK) begin
                if (state == DEC_EXT || state == DEC_EXT_BREAK) begin
                    state_nxt = DEC_EXT_BREAK;
                end else begin
                    state_nxt = DEC_BREAK;
                end
            end else begin
                // Extended keys are swallowed here, press and release alike
                state_nxt = DEC_NORMAL;
                emit_key = (state == DEC_NORMAL) || (state == DEC_BREAK);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= DEC_NORMAL;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Key event
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            key_valid <= 1'b0;
            key_index <= `KEY_UNKNOWN;
            key_release <= 1'b0;
        end else begin
            key_valid <= emit_key;
            if (emit_key) begin
                key_index <= lookup_key(code);
                key_release <= (state == DEC_BREAK);
            end
        end
    end

    // Every key event is the answer to a byte from the receiver one cycle earlier
    assert property (@(posedge clk) disable iff (!rstn) key_valid |-> $past(code_valid))
    else $error("ps2_key_decoder: key_valid without a preceding code_valid");

endmodule

/* logic/ps2_keypad_pkg.sv */
package ps2_keypad_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////////////////////////

    // One byte as it arrives from the keyboard
    typedef logic [7:0] scan_code_t;

    // Decoded key number
    // 0-9 digits, 10-15 hex letters A-F, 16 Enter, 17 Backspace, 18 Tab, 31 unknown
    typedef logic [4:0] key_index_t;

    //////////////////////////////////////////////////////////////////////
    // State machines
    //////////////////////////////////////////////////////////////////////

    // Frame receiver
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_SHIFT,
        RX_CHECK
    } rx_state_t;

    // Prefix tracking in the key decoder
    typedef enum logic [1:0] {
        DEC_NORMAL,
        DEC_BREAK,
        DEC_EXT,
        DEC_EXT_BREAK
    } dec_state_t;

endpackage

/* logic/ps2_keypad_top.sv */
module ps2_keypad_top
    import ps2_keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output key_index_t key_index,
    output logic       key_valid,
    output logic       key_release,
    output logic       frame_error
);

    logic ps2_clk_f;
    logic ps2_data_f;
    scan_code_t code;
    logic code_valid;

    ps2_line_filter u_filter (
        .clk        (clk),
        .rstn       (rstn),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .ps2_clk_f  (ps2_clk_f),
        .ps2_data_f (ps2_data_f)
    );

    ps2_frame_receiver u_receiver (
        .clk         (clk),
        .rstn        (rstn),
        .ps2_clk_f   (ps2_clk_f),
        .ps2_data_f  (ps2_data_f),
        .code        (code),
        .code_valid  (code_valid),
        .frame_error (frame_error)
    );

    ps2_key_decoder u_decoder (
        .clk         (clk),
        .rstn        (rstn),
        .code        (code),
        .code_valid  (code_valid),
        .key_index   (key_index),
        .key_valid   (key_valid),
        .key_release (key_release)
    );

endmodule

/* logic/ps2_line_filter.sv */
`include "ps2_keypad_defines.svh"

module ps2_line_filter (
    input  logic clk,
    input  logic rstn,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic ps2_clk_f,
    output logic ps2_data_f
);

    localparam int DIV_W = $clog2(`PS2_SAMPLE_DIV);
    localparam int FLT_LEN = `PS2_FILTER_LEN;

    logic [DIV_W-1:0] div_cnt;
    logic sample_tick;

    // Index 0 is the clock line, index 1 the data line
    logic [1:0] raw_line;
    logic [1:0] line_f;
    logic [1:0][FLT_LEN-1:0] line_hist;

    //////////////////////////////////////////////////////////////////////
    // Sample tick
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_cnt <= '0;
        end else if (sample_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign sample_tick = (div_cnt == DIV_W'(`PS2_SAMPLE_DIV - 1));

    //////////////////////////////////////////////////////////////////////
    // Glitch filters
    //////////////////////////////////////////////////////////////////////

    assign raw_line = {ps2_data, ps2_clk};

    // The history starts full of ones so the idle bus does not look like a change.
    // The output follows the history from the previous tick, which gives
    // a lag of FLT_LEN to FLT_LEN+1 ticks
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            line_hist <= '1;
            line_f <= 2'b11;
        end else if (sample_tick) begin
            for (int i = 0; i < 2; i++) begin
                line_hist[i] <= {raw_line[i], line_hist[i][FLT_LEN-1:1]};
                if (&line_hist[i]) begin
                    line_f[i] <= 1'b1;
                end else if (~|line_hist[i]) begin
                    line_f[i] <= 1'b0;
                end
            end
        end
    end

    assign ps2_clk_f = line_f[0];
    assign ps2_data_f = line_f[1];

    // A filtered level may only move at the edge that carries a sample tick
    assert property (@(posedge clk) disable iff (!rstn)
        $changed({ps2_data_f, ps2_clk_f}) |-> $past(sample_tick))
    else $error("ps2_line_filter: filtered line changed outside a sample tick");

endmodule

/* ps2_keypad.f */
+incdir+include
logic/ps2_keypad_pkg.sv
logic/ps2_line_filter.sv
logic/ps2_frame_receiver.sv
logic/ps2_key_decoder.sv
logic/ps2_keypad_top.sv
testbench/ps2_keypad_tb.sv

/* testbench/ps2_keypad_tb.sv */
`include "ps2_keypad_defines.svh"

module ps2_keypad_tb
    import ps2_keypad_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TESTS = 28;
    localparam int MAX_BYTES = 4;
    localparam int HALF_BIT = 48;
    localparam int CYCLE_LIMIT = N_TESTS * 3 * 1200;
    localparam int EVENT_WAIT = 600;
    localparam int QUIET_CYCLES = 200;
    // Long enough for the receiver to give up on a partial frame
    localparam int TIMEOUT_GAP = `PS2_BIT_TIMEOUT * `PS2_SAMPLE_DIV + 256;
    // Worst-case lag of the line filter in clk cycles
    localparam int SETTLE_CYCLES = (`PS2_FILTER_LEN + 1) * `PS2_SAMPLE_DIV;

    logic clk;
    logic rstn;
    logic ps2_clk;
    logic ps2_data;
    key_index_t key_index;
    logic key_valid;
    logic key_release;
    logic frame_error;

    // Stimulus table with one entry per test
    string      t_name    [N_TESTS];
    int         t_nbytes  [N_TESTS];
    logic [7:0] t_bytes   [N_TESTS][MAX_BYTES];
    bit         t_bad_par [N_TESTS];
    bit         t_glitch  [N_TESTS];
    bit         t_cut     [N_TESTS];
    int         t_exp_idx [N_TESTS];
    int         t_exp_rel [N_TESTS];
    int         t_exp_kv  [N_TESTS];
    int         t_exp_fe  [N_TESTS];
    int         n_loaded = 0;

    int kv_count = 0;
    int fe_count = 0;
    key_index_t last_idx;
    logic last_rel;
    int value_errors = 0;
    int wait_errors = 0;
    int cycle_cnt = 0;

    ps2_keypad_top i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key_index   (key_index),
        .key_valid   (key_valid),
        .key_release (key_release),
        .frame_error (frame_error)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // The event monitor samples on the falling clock edge where the outputs are stable
    always @(negedge clk) begin
        if (rstn) begin
            if (key_valid) begin
                kv_count++;
                last_idx = key_index;
                last_rel = key_release;
            end
            if (frame_error) begin
                fe_count++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checking and table setup
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED %s: %s expected %0d, actual %0d", test, what, expected, actual);
            value_errors++;
        end
    endtask

    // Bytes are packed first byte in the top eight bits
    task automatic add_test(input string name, input int nbytes, input logic [31:0] seq,
                            input bit bad_par, input bit glitch, input bit cut,
                            input int exp_idx, input int exp_rel, input int exp_kv,
                            input int exp_fe);
        t_name[n_loaded] = name;
        t_nbytes[n_loaded] = nbytes;
        for (int k = 0; k < MAX_BYTES; k++) begin
            t_bytes[n_loaded][k] = seq[31 - 8 * k -: 8];
        end
        t_bad_par[n_loaded] = bad_par;
        t_glitch[n_loaded] = glitch;
        t_cut[n_loaded] = cut;
        t_exp_idx[n_loaded] = exp_idx;
        t_exp_rel[n_loaded] = exp_rel;
        t_exp_kv[n_loaded] = exp_kv;
        t_exp_fe[n_loaded] = exp_fe;
        n_loaded++;
    endtask

    task automatic load_table();
        logic [7:0] make_code [19];
        string key_name [19];
        // Set 2 make codes in key index order
        make_code = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
                      8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h5A, 8'h66, 8'h0D};
        key_name = '{"0", "1", "2", "3", "4", "5", "6", "7", "8", "9",
                     "A", "B", "C", "D", "E", "F", "enter", "backspace", "tab"};
        for (int i = 0; i < 19; i++) begin
            add_test({"make ", key_name[i]}, 1, {make_code[i], 24'h0}, 0, 0, 0, i, 0, 1, 0);
        end
        add_test("break 1", 2, 32'hF016_0000, 0, 0, 0, 1, 1, 1, 0);
        add_test("break enter", 2, 32'hF05A_0000, 0, 0, 0, 16, 1, 1, 0);
        add_test("unmapped 15", 1, 32'h1500_0000, 0, 0, 0, `KEY_UNKNOWN, 0, 1, 0);
        add_test("bad parity", 2, 32'h2E3D_0000, 1, 0, 0, 7, 0, 1, 1);
        add_test("extended make", 3, 32'hE075_4600, 0, 0, 0, 9, 0, 1, 0);
        add_test("extended break", 4, 32'hE0F0_753E, 0, 0, 0, 8, 0, 1, 0);
        add_test("glitch make", 1, 32'h2400_0000, 0, 1, 0, 14, 0, 1, 0);
        add_test("glitch break", 2, 32'hF066_0000, 0, 1, 0, 17, 1, 1, 0);
        add_test("cut frame", 1, 32'h0D00_0000, 0, 0, 1, 18, 0, 1, 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // PS/2 device model
    //////////////////////////////////////////////////////////////////////

    // Flip one line for 1 to 3 cycles somewhere in a window of span cycles
    task automatic glitch_line(input bit on_data, input int span, input int first,
                               input int last);
        int offset;
        int width;
        offset = $urandom_range(last, first);
        width = $urandom_range(3, 1);
        repeat (offset) @(negedge clk);
        if (on_data) begin
            ps2_data = ~ps2_data;
        end else begin
            ps2_clk = ~ps2_clk;
        end
        repeat (width) @(negedge clk);
        if (on_data) begin
            ps2_data = ~ps2_data;
        end else begin
            ps2_clk = ~ps2_clk;
        end
        repeat (span - offset - width) @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input bit bad_parity, input bit glitch,
                              input int nbits);
        logic [10:0] bits;
        int glitch_bit;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        glitch_bit = $urandom_range(nbits - 1, 0);
        for (int i = 0; i < nbits; i++) begin
            // Data moves in the middle of the high phase
            repeat (HALF_BIT / 2) @(negedge clk);
            ps2_data = bits[i];
            if (glitch && i == glitch_bit) begin
                // The clock glitch comes after the filtered clock has settled high
                glitch_line(1'b0, HALF_BIT / 2, SETTLE_CYCLES - HALF_BIT / 2, 18);
            end else begin
                repeat (HALF_BIT / 2) @(negedge clk);
            end
            ps2_clk = 1'b0;
            if (glitch && i == glitch_bit) begin
                glitch_line(1'b1, HALF_BIT, 14, 40);
            end else begin
                repeat (HALF_BIT) @(negedge clk);
            end
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    task automatic run_test(input int t);
        int kv_base;
        int fe_base;
        int waited;
        @(posedge clk);
        kv_base = kv_count;
        fe_base = fe_count;
        if (t_cut[t]) begin
            send_frame(8'($urandom), 1'b0, 1'b0, 5);
            repeat (TIMEOUT_GAP) @(negedge clk);
        end
        for (int k = 0; k < t_nbytes[t]; k++) begin
            send_frame(t_bytes[t][k], t_bad_par[t] && k == 0, t_glitch[t], 11);
            repeat ($urandom_range(100, 20)) @(negedge clk);
        end
        waited = 0;
        while ((kv_count - kv_base < t_exp_kv[t] || fe_count - fe_base < t_exp_fe[t]) &&
               waited < EVENT_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (kv_count - kv_base < t_exp_kv[t] || fe_count - fe_base < t_exp_fe[t]) begin
            $display("Test %s: the DUT gave no response within %0d cycles", t_name[t],
                     EVENT_WAIT);
            wait_errors++;
        end
        // Extra events would show up here
        repeat (QUIET_CYCLES) @(posedge clk);
        check_value(t_name[t], "key_valid count", t_exp_kv[t], kv_count - kv_base);
        check_value(t_name[t], "frame_error count", t_exp_fe[t], fe_count - fe_base);
        if (t_exp_kv[t] > 0) begin
            check_value(t_name[t], "key_index", t_exp_idx[t], int'(last_idx));
            check_value(t_name[t], "key_release", t_exp_rel[t], int'(last_rel));
        end
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        void'($urandom(34671));
        load_table();
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        repeat (20) @(negedge clk);
        for (int t = 0; t < n_loaded; t++) begin
            run_test(t);
        end
        $display("Errors: %0d wrong values, %0d missing responses", value_errors, wait_errors);
        if (value_errors == 0 && wait_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Errors: %0d wrong values, %0d missing responses", value_errors, wait_errors);
        $display("** FAIL **");
        $finish;
    end

endmodule
